// File: design/nes_ctrl_pkg.sv
/*
 * Controller port constants, host joystick word and pad byte types,
 * per-port serial frame and load/shift command structs
 */

package nes_ctrl_pkg;

	////////////////////////////////////////////////////////////////////
	// Basic widths and types
	////////////////////////////////////////////////////////////////////

	localparam int NUM_PORTS  = 2;
	localparam int FRAME_BITS = 24;  // Pad byte, extra byte, signature

	// Bits 0 right, 1 left, 2 down, 3 up, 4 A, 5 B, 6 select, 7 start, 10 mic
	typedef logic [10:0] host_joy_t;

	typedef logic [7:0] pad_byte_t;  // Console order, A in bit 0
	typedef logic [FRAME_BITS-1:0] pad_frame_t;

	// Microphone duty, counter wraps at MIC_PERIOD
	localparam int MIC_PERIOD = 251;
	localparam int MIC_ON     = 215;

	// Four-player adapter signatures
	localparam pad_byte_t SIG_PORT0 = 8'h08;
	localparam pad_byte_t SIG_PORT1 = 8'h04;

	////////////////////////////////////////////////////////////////////
	// Grouped signals
	////////////////////////////////////////////////////////////////////

	typedef struct packed {
		host_joy_t a;
		host_joy_t b;
		host_joy_t c;
		host_joy_t d;
	} joy_bus_t;

	typedef struct packed {
		logic joy_swap;  // Exchange pads A and B
		logic multitap;
	} pad_cfg_t;

	typedef struct packed {
		logic       load;
		logic       shift;
		pad_frame_t frame;
	} pad_cmd_t;

endpackage

// File: design/nes_cart_pkg.sv
/*
 * iNES header layout constants, memory address and byte types,
 * mapper flag word and cartridge loader states
 */

package nes_cart_pkg;

	////////////////////////////////////////////////////////////////////
	// Header and memory layout
	////////////////////////////////////////////////////////////////////

	localparam int HDR_BYTES      = 16;
	localparam int PRG_PAGE_SHIFT = 14;  // 16 KiB PRG pages
	localparam int CHR_PAGE_SHIFT = 13;  // 8 KiB CHR pages

	typedef logic [21:0] mem_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [2:0]  size_code_t;  // log2 of pages, capped at 7

	localparam mem_addr_t CHR_BASE = 22'h200000;

	// "NES" followed by EOF
	localparam byte_t MAGIC0 = 8'h4E;
	localparam byte_t MAGIC1 = 8'h45;
	localparam byte_t MAGIC2 = 8'h53;
	localparam byte_t MAGIC3 = 8'h1A;

	////////////////////////////////////////////////////////////////////
	// Mapper flag word handed to the console core
	////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [1:0] reserved;
		logic [3:0] prg_ram_shift;  // NES 2.0 only
		logic       has_saves;
		byte_t      submapper;      // NES 2.0 only
		logic       four_screen;
		logic       has_chr_ram;
		logic       mirroring;
		size_code_t chr_size;
		size_code_t prg_size;
		byte_t      mapper;
	} mapper_flags_t;

	typedef enum logic [2:0] {
		S_HEADER,
		S_PRG,
		S_CHR,
		S_ERROR,
		S_DONE
	} loader_state_t;

endpackage

// File: design/ines_header_decode.sv
/*
 * iNES header decoder: magic and trainer check, NES 2.0 and dirty
 * header detection, size codes and the packed mapper flag word
 */

`timescale 1ns/1ps

module ines_header_decode (
	input  nes_cart_pkg::byte_t         header [nes_cart_pkg::HDR_BYTES],
	input  logic                        invert_mirroring,
	output nes_cart_pkg::mapper_flags_t flags,
	output logic                        valid,
	output nes_cart_pkg::byte_t         prg_pages,
	output nes_cart_pkg::byte_t         chr_pages
);
	import nes_cart_pkg::*;

	// Smallest k with pages <= 2**k, saturating at 7
	function automatic size_code_t size_code(input byte_t pages);
		size_code_t k;
		k = 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (pages <= (8'd1 << i))
				k = i[2:0];
		end
		return k;
	endfunction

	logic is_nes20;
	logic tail_nz;   // Any of bytes 10..15 nonzero
	logic is_dirty;

	assign prg_pages = header[4];
	assign chr_pages = header[5];  // Zero means CHR RAM

	assign valid = (header[0] == MAGIC0) && (header[1] == MAGIC1) &&
		(header[2] == MAGIC2) && (header[3] == MAGIC3) &&
		!header[6][2];  // Trainers not supported

	////////////////////////////////////////////////////////////////////
	// Format detection
	////////////////////////////////////////////////////////////////////

	assign is_nes20 = (header[7][3:2] == 2'b10);

	always_comb begin
		tail_nz = 1'b0;
		for (int i = 10; i < HDR_BYTES; i++)
			tail_nz = tail_nz | (|header[i]);
	end

	// Junk in old headers would corrupt the mapper high nibble
	assign is_dirty = !is_nes20 && ((|header[9][7:1]) || tail_nz);

	////////////////////////////////////////////////////////////////////
	// Flag word
	////////////////////////////////////////////////////////////////////

	always_comb begin
		flags.reserved      = '0;
		flags.prg_ram_shift = is_nes20 ? header[10][3:0] : 4'h0;
		flags.has_saves     = header[6][1];  // Battery backed RAM
		flags.submapper     = is_nes20 ? header[8] : 8'h00;
		flags.four_screen   = header[6][3];
		flags.has_chr_ram   = (chr_pages == 8'h00);
		flags.mirroring     = header[6][0] ^ invert_mirroring;
		flags.chr_size      = size_code(chr_pages);
		flags.prg_size      = size_code(prg_pages);
		flags.mapper        = {is_dirty ? 4'h0 : header[7][7:4], header[6][7:4]};
	end

endmodule

// File: design/game_loader.sv
/*
 * Cartridge file loader: header capture, PRG and CHR write address
 * generation, busy/done/error status and header decode instance
 */

`timescale 1ns/1ps

module game_loader (
	input  logic                        clk,
	input  logic                        reset_nes,
	input  logic                        downloading,
	input  nes_cart_pkg::byte_t         indata,
	input  logic                        indata_clk,
	input  logic                        invert_mirroring,
	output nes_cart_pkg::mem_addr_t     mem_addr,
	output nes_cart_pkg::byte_t         mem_data,
	output logic                        mem_write,
	output nes_cart_pkg::mapper_flags_t mapper_flags,
	output logic                        busy,
	output logic                        done,
	output logic                        error
);
	import nes_cart_pkg::*;

	loader_state_t state;
	logic [$clog2(HDR_BYTES)-1:0] ctr;  // Header byte index
	byte_t header [HDR_BYTES];
	mem_addr_t bytes_left;
	logic downloading_q;
	logic dl_start;
	logic hdr_valid;
	byte_t prg_pages;
	byte_t chr_pages;

	ines_header_decode ines_header_decode_inst (
		.header           (header),
		.invert_mirroring (invert_mirroring),
		.flags            (mapper_flags),
		.valid            (hdr_valid),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages)
	);

	assign dl_start = downloading & ~downloading_q;
	assign mem_data = indata;

	// Every strobed byte is written, no stall
	assign mem_write = indata_clk && (((state == S_HEADER) && downloading) ||
		(((state == S_PRG) || (state == S_CHR)) && (bytes_left != '0)));

	always_ff @(posedge clk) begin
		if ((state == S_HEADER) && mem_write)
			header[ctr] <= indata;
	end

	////////////////////////////////////////////////////////////////////
	// Loader FSM
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state         <= S_HEADER;
			ctr           <= '0;
			mem_addr      <= '0;
			bytes_left    <= '0;
			busy          <= 1'b0;
			done          <= 1'b0;
			error         <= 1'b0;
			downloading_q <= 1'b0;
		end else begin
			downloading_q <= downloading;
			if (dl_start) begin  // New file, start over
				state    <= S_HEADER;
				ctr      <= '0;
				mem_addr <= '0;
				busy     <= 1'b0;
				done     <= 1'b0;
				error    <= 1'b0;
			end else begin
				case (state)
					S_HEADER: if (mem_write) begin
						ctr      <= ctr + 1'b1;
						mem_addr <= mem_addr + 1'b1;
						if (ctr == HDR_BYTES - 1) begin
							// Bytes 0..6 already stored, decode is stable
							if (hdr_valid) begin
								state      <= S_PRG;
								busy       <= 1'b1;
								mem_addr   <= '0;
								bytes_left <= mem_addr_t'(prg_pages) << PRG_PAGE_SHIFT;
							end else begin
								state <= S_ERROR;
								done  <= 1'b1;
								error <= 1'b1;
							end
						end
					end
					S_PRG, S_CHR: begin
						if (bytes_left != '0) begin
							if (indata_clk) begin
								bytes_left <= bytes_left - 1'b1;
								mem_addr   <= mem_addr + 1'b1;
							end
						end else if (state == S_PRG) begin
							state      <= S_CHR;
							mem_addr   <= CHR_BASE;
							bytes_left <= mem_addr_t'(chr_pages) << CHR_PAGE_SHIFT;
						end else begin
							state <= S_DONE;
							done  <= 1'b1;
							busy  <= 1'b0;
						end
					end
					default: ;  // S_DONE and S_ERROR hold until next download
				endcase
			end
		end
	end

endmodule

// File: design/pad_load_mapper.sv
/*
 * Controller load mapper: host word to console button order,
 * per-port frame assembly and port clock falling edge detection
 */

`timescale 1ns/1ps

module pad_load_mapper (
	input  logic                                  clk,
	input  logic                                  reset_nes,
	input  nes_ctrl_pkg::joy_bus_t                joys,
	input  nes_ctrl_pkg::pad_cfg_t                cfg,
	input  logic                                  joypad_strobe,
	input  logic [nes_ctrl_pkg::NUM_PORTS-1:0]    joypad_clock,
	output nes_ctrl_pkg::pad_cmd_t                cmd [nes_ctrl_pkg::NUM_PORTS]
);
	import nes_ctrl_pkg::*;

	// Host bits 4..7 then 3..0 land on pad bits 0..7
	function automatic pad_byte_t to_pad(input host_joy_t j);
		return {j[0], j[1], j[2], j[3], j[7], j[6], j[5], j[4]};
	endfunction

	pad_byte_t pad_a;
	pad_byte_t pad_b;
	pad_byte_t pad_c;
	pad_byte_t pad_d;
	pad_frame_t frame [NUM_PORTS];
	logic [NUM_PORTS-1:0] last_clk;  // Port clock level one cycle back

	assign pad_a = to_pad(joys.a);
	assign pad_b = to_pad(joys.b);
	assign pad_c = to_pad(joys.c);
	assign pad_d = to_pad(joys.d);

	always_comb begin
		// Without the adapter the upper 16 bits read as all ones
		frame[0] = {cfg.multitap ? {SIG_PORT0, pad_c} : 16'hFFFF,
			cfg.joy_swap ? pad_b : pad_a};
		frame[1] = {cfg.multitap ? {SIG_PORT1, pad_d} : 16'hFFFF,
			cfg.joy_swap ? pad_a : pad_b};
	end

	always_ff @(posedge clk) begin
		if (reset_nes)
			last_clk <= '0;
		else
			last_clk <= joypad_clock;
	end

	always_comb begin
		for (int n = 0; n < NUM_PORTS; n++) begin
			cmd[n].load  = joypad_strobe;                  // Every cycle strobe is high
			cmd[n].shift = last_clk[n] & ~joypad_clock[n]; // Falling edge
			cmd[n].frame = frame[n];
		end
	end

endmodule

// File: design/pad_shift_port.sv
/*
 * One controller port: 24-bit frame register, parallel load,
 * right shift with zero fill, serial output from bit 0
 */

`timescale 1ns/1ps

module pad_shift_port (
	input  logic                   clk,
	input  logic                   reset_nes,
	input  nes_ctrl_pkg::pad_cmd_t cmd,
	output logic                   serial_bit
);
	import nes_ctrl_pkg::*;

	pad_frame_t bits_q;

	////////////////////////////////////////////////////////////////////
	// Shift register
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			bits_q <= '0;
		end else if (cmd.shift) begin
			// Old contents move out even if strobe is still high
			bits_q <= {1'b0, bits_q[FRAME_BITS-1:1]};
		end else if (cmd.load) begin
			bits_q <= cmd.frame;
		end
	end

	// Console samples the LSB
	assign serial_bit = bits_q[0];

endmodule

// File: design/pad_read_port.sv
/*
 * Controller read side: serial bits onto joy_data,
 * microphone duty counter and gated mic output
 */

`timescale 1ns/1ps

module pad_read_port (
	input  logic                               clk,
	input  logic                               reset_nes,
	input  logic [nes_ctrl_pkg::NUM_PORTS-1:0] serial_bits,
	input  logic                               mic_button,
	output logic [nes_ctrl_pkg::NUM_PORTS-1:0] joy_data,
	output logic                               mic
);
	import nes_ctrl_pkg::*;

	logic [$clog2(MIC_PERIOD)-1:0] mic_cnt;

	// Port n drives data bit n
	always_comb begin
		for (int n = 0; n < NUM_PORTS; n++)
			joy_data[n] = serial_bits[n];
	end

	////////////////////////////////////////////////////////////////////
	// Microphone pulse
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes)
			mic_cnt <= '0;
		else if (mic_cnt == MIC_PERIOD - 1)
			mic_cnt <= '0;  // Wrap after 250
		else
			mic_cnt <= mic_cnt + 1'b1;
	end

	// High phase only while the button is held
	assign mic = (mic_cnt < MIC_ON) && mic_button;

endmodule

// File: design/nes_host_bridge.sv
/*
 * Host bridge top: controller load mapper, shift ports and read port,
 * plus the cartridge file loader
 */

`timescale 1ns/1ps

module nes_host_bridge (
	input  logic                               clk,
	input  logic                               reset_nes,
	input  nes_ctrl_pkg::joy_bus_t             joys,
	input  nes_ctrl_pkg::pad_cfg_t             cfg,
	input  logic                               joypad_strobe,
	input  logic [nes_ctrl_pkg::NUM_PORTS-1:0] joypad_clock,
	input  logic                               downloading,
	input  nes_cart_pkg::byte_t                indata,
	input  logic                               indata_clk,
	input  logic                               invert_mirroring,
	output logic [nes_ctrl_pkg::NUM_PORTS-1:0] joy_data,
	output logic                               mic,
	output nes_cart_pkg::mem_addr_t            mem_addr,
	output nes_cart_pkg::byte_t                mem_data,
	output logic                               mem_write,
	output nes_cart_pkg::mapper_flags_t        mapper_flags,
	output logic                               busy,
	output logic                               done,
	output logic                               error
);
	import nes_ctrl_pkg::*;

	pad_cmd_t cmd [NUM_PORTS];
	logic [NUM_PORTS-1:0] serial_bits;

	////////////////////////////////////////////////////////////////////
	// Controller path
	////////////////////////////////////////////////////////////////////

	pad_load_mapper pad_load_mapper_inst (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.joys          (joys),
		.cfg           (cfg),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.cmd           (cmd)
	);

	for (genvar n = 0; n < NUM_PORTS; n++) begin : g_port
		pad_shift_port pad_shift_port_inst (
			.clk        (clk),
			.reset_nes  (reset_nes),
			.cmd        (cmd[n]),
			.serial_bit (serial_bits[n])
		);
	end

	pad_read_port pad_read_port_inst (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.serial_bits (serial_bits),
		.mic_button  (joys.a[10] | joys.b[10]),  // Either pad's mic key
		.joy_data    (joy_data),
		.mic         (mic)
	);

	////////////////////////////////////////////////////////////////////
	// Cartridge loader
	////////////////////////////////////////////////////////////////////

	game_loader game_loader_inst (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.downloading      (downloading),
		.indata           (indata),
		.indata_clk       (indata_clk),
		.invert_mirroring (invert_mirroring),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mem_write        (mem_write),
		.mapper_flags     (mapper_flags),
		.busy             (busy),
		.done             (done),
		.error            (error)
	);

endmodule

// File: tests/nes_host_bridge_tb.sv
/*
 * Testbench for the host bridge: controller serial streams, port
 * independence, mic duty and cartridge loads from the pattern file
 */

`timescale 1ns/1ps

module nes_host_bridge_tb;
	import nes_ctrl_pkg::*;
	import nes_cart_pkg::*;

	localparam int MAX_LINES  = 32;
	localparam int DONE_LIMIT = 64;  // Cycles allowed for done to rise
	localparam int PAD_LINE   = 1;
	localparam int LOAD_LINE  = 2;

	logic                 clk;
	logic                 reset_nes;
	joy_bus_t             joys;
	pad_cfg_t             cfg;
	logic                 joypad_strobe;
	logic [NUM_PORTS-1:0] joypad_clock;
	logic                 downloading;
	byte_t                indata;
	logic                 indata_clk;
	logic                 invert_mirroring;
	logic [NUM_PORTS-1:0] joy_data;
	logic                 mic;
	mem_addr_t            mem_addr;
	byte_t                mem_data;
	logic                 mem_write;
	mapper_flags_t        mapper_flags;
	logic                 busy;
	logic                 done;
	logic                 error;

	logic [171:0] patterns [MAX_LINES];  // Type code in bits 3:0
	int check_count;
	int error_count;
	int lines_run;

	nes_host_bridge nes_host_bridge_inst (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.joys             (joys),
		.cfg              (cfg),
		.joypad_strobe    (joypad_strobe),
		.joypad_clock     (joypad_clock),
		.downloading      (downloading),
		.indata           (indata),
		.indata_clk       (indata_clk),
		.invert_mirroring (invert_mirroring),
		.joy_data         (joy_data),
		.mic              (mic),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mem_write        (mem_write),
		.mapper_flags     (mapper_flags),
		.busy             (busy),
		.done             (done),
		.error            (error)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			error_count++;
			$display("mismatch %s got %h expected %h", name, got, exp);
		end
	endtask

	// Bit on the data line after n shifts, zeros once the frame is out
	function automatic logic stream_bit(input pad_frame_t stream, input int n);
		if (n < FRAME_BITS)
			return stream[n];
		return 1'b0;
	endfunction

	task automatic pulse_clock(input logic [NUM_PORTS-1:0] mask);
		@(posedge clk);
		joypad_clock <= mask;
		@(posedge clk);
		joypad_clock <= '0;
		@(posedge clk);  // Falling edge taken here
		@(negedge clk);
	endtask

	task automatic send_byte(input byte_t data, input logic exp_write,
		input mem_addr_t exp_addr);
		@(posedge clk);
		indata     <= data;
		indata_clk <= 1'b1;
		@(negedge clk);
		check_val("mem_write", mem_write, exp_write);
		if (exp_write) begin
			check_val("mem_addr", mem_addr, exp_addr);
			check_val("mem_data", mem_data, data);
		end
		@(posedge clk);
		indata_clk <= 1'b0;  // Idle cycle between bytes
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (!done && n < DONE_LIMIT) begin
			@(negedge clk);
			n++;
		end
		check_count++;
		assert (done === 1'b1) else begin
			error_count++;
			$display("done did not rise within %0d cycles", DONE_LIMIT);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Controller and mic cases
	//////////////////////////////////////////////////////////////////////

	task automatic run_pad_case(input logic [171:0] p);
		pad_frame_t exp0;
		pad_frame_t exp1;
		exp1 = p[27:4];
		exp0 = p[51:28];
		@(posedge clk);
		joys <= '{a: p[106:96], b: p[94:84], c: p[82:72], d: p[70:60]};
		cfg  <= '{joy_swap: p[56], multitap: p[52]};
		joypad_strobe <= 1'b1;
		@(posedge clk);
		joypad_strobe <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_val("joy_data[0]", joy_data[0], stream_bit(exp0, 0));
		check_val("joy_data[1]", joy_data[1], stream_bit(exp1, 0));
		// One port at a time, the other must hold its bit
		for (int i = 1; i <= FRAME_BITS + 1; i++) begin
			pulse_clock(2'b01);
			check_val("joy_data[0]", joy_data[0], stream_bit(exp0, i));
			check_val("joy_data[1]", joy_data[1], stream_bit(exp1, i - 1));
			pulse_clock(2'b10);
			check_val("joy_data[0]", joy_data[0], stream_bit(exp0, i));
			check_val("joy_data[1]", joy_data[1], stream_bit(exp1, i));
		end
	endtask

	task automatic check_mic(input logic button_a, input logic button_b);
		int high_cycles;
		@(posedge clk);
		joys <= '{a: {button_a, 10'h000}, b: {button_b, 10'h000}, c: '0, d: '0};
		high_cycles = 0;
		repeat (MIC_PERIOD) begin
			@(negedge clk);
			if (mic)
				high_cycles++;
		end
		check_val("mic high cycles", high_cycles, (button_a | button_b) ? MIC_ON : 0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Cartridge load cases
	//////////////////////////////////////////////////////////////////////

	task automatic run_load_case(input logic [171:0] p);
		byte_t hdr [HDR_BYTES];
		mapper_flags_t exp_flags;
		logic exp_err;
		int prg_bytes;
		int chr_bytes;
		for (int i = 0; i < HDR_BYTES; i++)
			hdr[i] = p[171 - 8 * i -: 8];
		exp_flags = p[43:12];
		exp_err   = p[4];
		prg_bytes = int'(hdr[4]) * 16384;
		chr_bytes = int'(hdr[5]) * 8192;
		@(posedge clk);
		downloading      <= 1'b1;
		invert_mirroring <= p[8];
		@(posedge clk);  // Restart edge
		for (int i = 0; i < HDR_BYTES; i++)
			send_byte(hdr[i], 1'b1, mem_addr_t'(i));
		@(negedge clk);
		check_val("busy", busy, !exp_err);
		if (exp_err) begin
			wait_done();
			// Later bytes must not reach memory
			repeat (4)
				send_byte(byte_t'($urandom), 1'b0, '0);
			check_val("done", done, 1'b1);
			check_val("error", error, 1'b1);
		end else begin
			for (int j = 0; j < prg_bytes; j++)
				send_byte(byte_t'($urandom), 1'b1, mem_addr_t'(j));
			for (int j = 0; j < chr_bytes; j++)
				send_byte(byte_t'($urandom), 1'b1, CHR_BASE + mem_addr_t'(j));
			wait_done();
			check_val("error", error, 1'b0);
			check_val("busy", busy, 1'b0);
			check_val("mapper_flags", mapper_flags, exp_flags);
		end
		@(posedge clk);
		downloading <= 1'b0;
		@(posedge clk);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(55434));
		check_count      = 0;
		error_count      = 0;
		lines_run        = 0;
		reset_nes        = 1'b1;
		joys             = '0;
		cfg              = '0;
		joypad_strobe    = 1'b0;
		joypad_clock     = '0;
		downloading      = 1'b0;
		indata           = '0;
		indata_clk       = 1'b0;
		invert_mirroring = 1'b0;
		$readmemh("tests/bridge_patterns.mem", patterns);

		repeat (2) @(posedge clk);
		reset_nes <= 1'b0;
		@(negedge clk);
		check_val("busy", busy, 1'b0);
		check_val("done", done, 1'b0);
		check_val("error", error, 1'b0);
		check_val("mem_write", mem_write, 1'b0);

		for (int n = 0; n < MAX_LINES; n++) begin
			if (patterns[n][3:0] === PAD_LINE) begin
				run_pad_case(patterns[n]);
				lines_run++;
			end else if (patterns[n][3:0] === LOAD_LINE) begin
				run_load_case(patterns[n]);
				lines_run++;
			end
		end
		check_count++;
		assert (lines_run > 0) else begin
			error_count++;
			$display("no usable lines in the pattern file");
		end

		check_mic(1'b0, 1'b0);  // Released first
		check_mic(1'b1, 1'b0);
		check_mic(1'b0, 1'b1);

		$display("checks %0d errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: tests/bridge_patterns.mem
// Type 1 (last digit): host words a b c d, swap, multitap, port 0 frame, port 1 frame
// Type 2: header bytes 0..15, expected flags, invert_mirroring, expected error
// Frames are listed as shifted out, bit 0 first; flags unused on error lines

// Controller lines, all swap and multitap combinations
011_0A2_04C_0C0_0_0_FFFF81_FFFF4A_1
011_0A2_04C_0C0_1_0_FFFF4A_FFFF81_1
011_0A2_04C_0C0_0_1_083481_040C4A_1
011_0A2_04C_0C0_1_1_08344A_040C81_1
// Mic bit set on A, single buttons elsewhere
4FF_000_001_010_1_1_088000_0401FF_1

// Plain iNES, 1 PRG page, 1 CHR page, vertical mirroring
4E45531A_01011100_00000000_00000000_00004001_0_0_2
// NES 2.0 with submapper, PRG RAM shift, CHR RAM, inverted mirroring
4E45531A_02004218_35000700_00000000_1E6AC114_1_0_2
// Dirty header, junk in bytes 12 and 13, four screen
4E45531A_01012850_00000000_44750000_00014002_1_0_2
// Bad magic
4E45531B_01010000_00000000_00000000_00000000_0_1_2
// Trainer present
4E45531A_01010400_00000000_00000000_00000000_0_1_2
// Clean header again after errors, byte 9 bit 0 allowed
4E45531A_0102A030_00010000_00000000_0000083A_0_0_2

// File: all.f
design/nes_ctrl_pkg.sv
design/nes_cart_pkg.sv
design/ines_header_decode.sv
design/game_loader.sv
design/pad_load_mapper.sv
design/pad_shift_port.sv
design/pad_read_port.sv
design/nes_host_bridge.sv
tests/nes_host_bridge_tb.sv

// File: Bender.yml
package:
  name: nes_host_bridge

sources:
  - files:
      - design/nes_ctrl_pkg.sv
      - design/nes_cart_pkg.sv
      - design/ines_header_decode.sv
      - design/game_loader.sv
      - design/pad_load_mapper.sv
      - design/pad_shift_port.sv
      - design/pad_read_port.sv
      - design/nes_host_bridge.sv
  - target: simulation
    files:
      - tests/nes_host_bridge_tb.sv
